//--- design/mc_link_pkg.sv
package mc_link_pkg;

  localparam int addr_width_c = 14; // Word address.
  localparam int data_width_c = 32;
  localparam int eff_addr_width_c = addr_width_c + 2; // Byte address.

  localparam int mem_words_c = 64;
  localparam int mem_index_width_c = $clog2(mem_words_c);

  // First byte address served by endpoint 1.
  localparam logic [eff_addr_width_c-1:0] split_addr_c = 16'h0100;

  localparam int max_outstanding_c = 15;
  localparam int cnt_width_c = 4;

  typedef enum logic {
    mc_op_load  = 1'b0,
    mc_op_store = 1'b1
  } mc_op_e;

  typedef struct packed {
    logic [data_width_c-3:0] zero;
    logic [1:0]              part_sel; // Byte lane.
  } mc_load_info_s;

  // Stores carry a data word, loads carry the byte lane.
  typedef union packed {
    logic [data_width_c-1:0] data;
    mc_load_info_s           load_info;
  } mc_payload_u;

  typedef struct packed {
    mc_op_e                  op;
    logic [addr_width_c-1:0] addr;
    mc_payload_u             payload;
  } mc_fwd_packet_s;

  typedef struct packed {
    mc_op_e                  op;
    logic [data_width_c-1:0] data;
  } mc_ret_packet_s;

  typedef struct packed {
    logic           v;
    mc_fwd_packet_s pkt;
  } mc_fwd_link_s;

  typedef struct packed {
    logic           v;
    mc_ret_packet_s pkt;
  } mc_ret_link_s;

endpackage

//--- design/mc_mem_endpoint.sv
`timescale 1ns/1ps

module mc_mem_endpoint (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mc_link_pkg::mc_fwd_link_s req_i,
  output logic                      req_ready_o,
  output mc_link_pkg::mc_ret_link_s ret_o,
  input  logic                      ret_ready_i
);

  logic [mc_link_pkg::data_width_c-1:0] mem_r [mc_link_pkg::mem_words_c];

  logic                                      ret_v_r;
  mc_link_pkg::mc_ret_packet_s               ret_pkt_r;
  mc_link_pkg::mc_ret_packet_s               ret_pkt_n;
  logic                                      accept;
  logic                                      is_store;
  logic [mc_link_pkg::mem_index_width_c-1:0] mem_index;
  logic [mc_link_pkg::data_width_c-1:0]      rd_word;
  logic [7:0]                                rd_byte;
  logic [1:0]                                lane;

  // One-entry return buffer is free when empty or draining now.
  assign req_ready_o = ~ret_v_r | ret_ready_i;
  assign accept      = req_i.v & req_ready_o;

  assign is_store  = (req_i.pkt.op == mc_link_pkg::mc_op_store);
  assign mem_index = req_i.pkt.addr[mc_link_pkg::mem_index_width_c-1:0]; // Upper bits alias.
  assign lane      = req_i.pkt.payload.load_info.part_sel;
  assign rd_word   = mem_r[mem_index];
  assign rd_byte   = rd_word[8*lane +: 8];

  always_comb begin
    ret_pkt_n.op = req_i.pkt.op;
    if (is_store) begin
      ret_pkt_n.data = req_i.pkt.payload.data; // Echo of the stored word.
    end else begin
      ret_pkt_n.data = {{(mc_link_pkg::data_width_c-8){1'b0}}, rd_byte};
    end
  end

  // Memory reads zero after reset.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mc_link_pkg::mem_words_c; i++) begin
        mem_r[i] <= '0;
      end
    end else if (accept && is_store) begin
      mem_r[mem_index] <= req_i.pkt.payload.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ret_v_r <= 1'b0;
    end else if (accept) begin
      ret_v_r <= 1'b1;
    end else if (ret_ready_i) begin
      ret_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ret_pkt_r <= ret_pkt_n;
    end
  end

  assign ret_o.v   = ret_v_r;
  assign ret_o.pkt = ret_pkt_r;

endmodule

//--- design/mc_outstanding_counter.sv
`timescale 1ns/1ps

module mc_outstanding_counter (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                inc_i,
  input  logic                                dec_i,
  output logic [mc_link_pkg::cnt_width_c-1:0] count_o
);

  logic [mc_link_pkg::cnt_width_c-1:0] count_r;
  logic                                at_max;
  logic                                at_zero;

  assign at_max  = (count_r == mc_link_pkg::cnt_width_c'(mc_link_pkg::max_outstanding_c));
  assign at_zero = (count_r == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (inc_i && !dec_i) begin
      if (!at_max) begin
        count_r <= count_r + 1'b1;
      end
    end else if (dec_i && !inc_i) begin
      if (!at_zero) begin
        count_r <= count_r - 1'b1; // Never wraps below zero.
      end
    end
  end

  assign count_o = count_r;

endmodule

//--- design/mc_rr_arbiter_2to1.sv
`timescale 1ns/1ps

module mc_rr_arbiter_2to1 (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [1:0]                             v_i,
  input  mc_link_pkg::mc_ret_packet_s [1:0]      data_i,
  input  logic                                   yumi_i,
  output logic                                   v_o,
  output mc_link_pkg::mc_ret_packet_s            data_o,
  output logic                                   tag_o,
  output logic [1:0]                             grant_o
);

  logic last_r; // Index of the last winner.
  logic tag;

  // After input 0 won, input 1 gets first look, and the other way round.
  always_comb begin
    if (!last_r) begin
      tag = v_i[1];
    end else begin
      tag = ~v_i[0];
    end
  end

  assign v_o    = |v_i;
  assign tag_o  = tag;
  assign data_o = data_i[tag];

  always_comb begin
    grant_o = 2'b00;
    if (v_o) begin
      grant_o[tag] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r <= 1'b1;
    end else if (yumi_i) begin
      last_r <= tag;
    end
  end

endmodule

//--- design/mc_subsystem_top.sv
`timescale 1ns/1ps

module mc_subsystem_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mc_link_pkg::mc_fwd_link_s req_i,
  output logic                      req_ready_o,
  output mc_link_pkg::mc_ret_link_s ret_o,
  input  logic                      ret_ready_i
);

  mc_link_pkg::mc_fwd_link_s [1:0] ep_req;
  logic [1:0]                      ep_req_ready;
  mc_link_pkg::mc_ret_link_s [1:0] ep_ret;
  logic [1:0]                      ep_ret_ready;

  mc_switch_1x2 switch_u (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .ep_req_o       (ep_req),
    .ep_req_ready_i (ep_req_ready),
    .ep_ret_i       (ep_ret),
    .ep_ret_ready_o (ep_ret_ready),
    .ret_o          (ret_o),
    .ret_ready_i    (ret_ready_i)
  );

  // Endpoint 0 serves bytes below the split, endpoint 1 the rest.
  for (genvar k = 0; k < 2; k++) begin : g_ep
    mc_mem_endpoint ep_u (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (ep_req[k]),
      .req_ready_o (ep_req_ready[k]),
      .ret_o       (ep_ret[k]),
      .ret_ready_i (ep_ret_ready[k])
    );
  end

endmodule

//--- design/mc_switch_1x2.sv
`timescale 1ns/1ps

module mc_switch_1x2 (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  mc_link_pkg::mc_fwd_link_s           req_i,
  output logic                                req_ready_o,
  output mc_link_pkg::mc_fwd_link_s [1:0]     ep_req_o,
  input  logic [1:0]                          ep_req_ready_i,
  input  mc_link_pkg::mc_ret_link_s [1:0]     ep_ret_i,
  output logic [1:0]                          ep_ret_ready_o,
  output mc_link_pkg::mc_ret_link_s           ret_o,
  input  logic                                ret_ready_i
);

  typedef enum logic [1:0] {
    lock_idle,
    lock_send0,
    lock_send1
  } lock_state_e;

  lock_state_e lock_state_r;
  lock_state_e lock_state_n;

  logic [mc_link_pkg::eff_addr_width_c-1:0] eff_addr;
  logic [1:0]                               part_sel;
  logic                                     fwd_select; // High selects endpoint 1.
  logic                                     side_ok;
  logic [1:0]                               lock_mask;
  logic                                     send0;
  logic                                     send1;
  logic                                     send_drained;

  logic [1:0]                               ret_grant;
  logic [1:0]                               ret_fire;
  logic                                     ret_v;
  mc_link_pkg::mc_ret_packet_s              ret_pkt;
  logic [mc_link_pkg::cnt_width_c-1:0]      send_cnt;

  // Byte lane only counts for loads.
  assign part_sel = (req_i.pkt.op == mc_link_pkg::mc_op_load) ?
                    req_i.pkt.payload.load_info.part_sel : 2'b00;
  assign eff_addr   = {req_i.pkt.addr, part_sel};
  assign fwd_select = (eff_addr >= mc_link_pkg::split_addr_c);

  assign lock_mask[0] = (lock_state_r == lock_send0);
  assign lock_mask[1] = (lock_state_r == lock_send1);
  assign side_ok = (lock_state_r == lock_idle) | lock_mask[fwd_select];

  assign ep_req_o[0].pkt = req_i.pkt;
  assign ep_req_o[1].pkt = req_i.pkt;
  assign ep_req_o[0].v   = req_i.v & ~fwd_select & side_ok;
  assign ep_req_o[1].v   = req_i.v &  fwd_select & side_ok;

  // Held back while the other side still owes returns.
  assign req_ready_o = side_ok & ep_req_ready_i[fwd_select];

  assign send0 = ep_req_o[0].v & ep_req_ready_i[0];
  assign send1 = ep_req_o[1].v & ep_req_ready_i[1];

  mc_rr_arbiter_2to1 ret_arb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     ({ep_ret_i[1].v & lock_mask[1], ep_ret_i[0].v & lock_mask[0]}),
    .data_i  ({ep_ret_i[1].pkt, ep_ret_i[0].pkt}),
    .yumi_i  (ret_v & ret_ready_i),
    .v_o     (ret_v),
    .data_o  (ret_pkt),
    .tag_o   (),
    .grant_o (ret_grant)
  );

  assign ret_o.v   = ret_v;
  assign ret_o.pkt = ret_pkt;

  assign ep_ret_ready_o = {2{ret_ready_i}} & lock_mask;
  assign ret_fire       = ret_grant & ep_ret_ready_o;

  mc_outstanding_counter send_cnt_u (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (send0 | send1),
    .dec_i   (|ret_fire),
    .count_o (send_cnt)
  );

  assign send_drained = (send_cnt == '0) & ~send0 & ~send1;

  always_comb begin
    lock_state_n = lock_state_r;
    case (lock_state_r)
      lock_idle: begin
        if (send0) begin
          lock_state_n = lock_send0;
        end else if (send1) begin
          lock_state_n = lock_send1;
        end
      end
      lock_send0, lock_send1: begin
        if (send_drained) begin
          lock_state_n = lock_idle;
        end
      end
      default: lock_state_n = lock_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_state_r <= lock_idle;
    end else begin
      lock_state_r <= lock_state_n;
    end
  end

endmodule

//--- sources.f
design/mc_link_pkg.sv
design/mc_outstanding_counter.sv
design/mc_rr_arbiter_2to1.sv
design/mc_switch_1x2.sv
design/mc_mem_endpoint.sv
design/mc_subsystem_top.sv
tb/mc_subsystem_assertions.sv
tb/mc_subsystem_checker.sv
tb/mc_subsystem_tb.sv

//--- tb/mc_subsystem_assertions.sv
`timescale 1ns/1ps

module mc_subsystem_assertions (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  mc_link_pkg::mc_fwd_link_s [1:0] ep_req_i,
  input  mc_link_pkg::mc_ret_link_s [1:0] ep_ret_i,
  input  logic [1:0]                      lock_mask_i,
  input  mc_link_pkg::mc_ret_link_s       ret_i,
  input  logic                            ret_ready_i
);

  int fail_count = 0;

  // A side is active while it gets a request or holds a return.
  one_side_active: assert property (@(posedge clk_i) disable iff (reset_i)
      !((ep_req_i[0].v || ep_ret_i[0].v) && (ep_req_i[1].v || ep_ret_i[1].v)))
    else begin
      $error("Both endpoints active in one cycle");
      fail_count++;
    end

  // Return held while the host stalls.
  ret_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (ret_i.v && !ret_ready_i) |=> (ret_i.v && $stable(ret_i.pkt)))
    else begin
      $error("Host return changed or dropped under back-pressure");
      fail_count++;
    end

  no_unlocked_ret0: assert property (@(posedge clk_i) disable iff (reset_i)
      ep_ret_i[0].v |-> lock_mask_i[0])
    else begin
      $error("Return waiting at endpoint 0 while unlocked");
      fail_count++;
    end

  no_unlocked_ret1: assert property (@(posedge clk_i) disable iff (reset_i)
      ep_ret_i[1].v |-> lock_mask_i[1])
    else begin
      $error("Return waiting at endpoint 1 while unlocked");
      fail_count++;
    end

endmodule

bind mc_switch_1x2 mc_subsystem_assertions switch_checks (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .ep_req_i    (ep_req_o),
  .ep_ret_i    (ep_ret_i),
  .lock_mask_i (lock_mask),
  .ret_i       (ret_o),
  .ret_ready_i (ret_ready_i)
);

//--- tb/mc_subsystem_checker.sv
`timescale 1ns/1ps

module mc_subsystem_checker (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mc_link_pkg::mc_fwd_link_s req_i,
  input  logic                      req_ready_i,
  input  mc_link_pkg::mc_ret_link_s ret_i,
  input  logic                      ret_ready_i,
  input  logic [127:0]              test_name_i,
  input  logic                      end_i,
  output int                        error_count_o,
  output int                        pending_o,
  output int                        returns_o
);

  logic [31:0]                 shadow [2][64]; // Side, then word.
  mc_link_pkg::mc_ret_packet_s expect_q [$];
  logic [127:0]                name_q [$];
  int                          errors = 0;
  int                          accepted = 0;
  int                          returned = 0;
  logic                        reset_d = 1'b0;
  logic                        end_seen = 1'b0;

  always @(posedge clk_i) begin : watch
    int                          eff;
    int                          side;
    int                          word;
    mc_link_pkg::mc_ret_packet_s exp_pkt;
    logic [127:0]                exp_name;
    if (reset_i) begin
      for (int s = 0; s < 2; s++) begin
        for (int w = 0; w < 64; w++) begin
          shadow[s][w] = '0;
        end
      end
      expect_q.delete();
      name_q.delete();
    end else begin
      if (reset_d && ret_i.v !== 1'b0) begin
        $display("Host return valid was not low when reset ended");
        errors++;
      end
      // A return never belongs to a request of the same edge.
      if (ret_i.v && ret_ready_i) begin
        returned++;
        if (expect_q.size() == 0) begin
          $display("Return arrived with no request outstanding, data %h", ret_i.pkt.data);
          errors++;
        end else begin
          exp_pkt  = expect_q.pop_front();
          exp_name = name_q.pop_front();
          if (ret_i.pkt !== exp_pkt) begin
            $display("[FAIL] %0s expected op %0d data %h, actual op %0d data %h",
                     exp_name, exp_pkt.op, exp_pkt.data, ret_i.pkt.op, ret_i.pkt.data);
            errors++;
          end
        end
      end
      if (req_i.v && req_ready_i) begin
        accepted++;
        eff = int'(req_i.pkt.addr) * 4;
        if (req_i.pkt.op == mc_link_pkg::mc_op_load) begin
          eff = eff + int'(req_i.pkt.payload.load_info.part_sel);
        end
        side = (eff >= int'(mc_link_pkg::split_addr_c)) ? 1 : 0;
        word = int'(req_i.pkt.addr) % 64; // Upper word bits alias.
        exp_pkt.op = req_i.pkt.op;
        if (req_i.pkt.op == mc_link_pkg::mc_op_store) begin
          shadow[side][word] = req_i.pkt.payload.data;
          exp_pkt.data = req_i.pkt.payload.data;
        end else begin
          exp_pkt.data = (shadow[side][word] >> (8 * req_i.pkt.payload.load_info.part_sel))
                         & 32'h0000_00ff;
        end
        expect_q.push_back(exp_pkt);
        name_q.push_back(test_name_i);
      end
      if (end_i && !end_seen) begin
        end_seen = 1'b1;
        if (accepted != returned) begin
          $display("%0d requests were accepted but %0d returns arrived", accepted, returned);
          errors++;
        end
      end
    end
    reset_d       <= reset_i;
    error_count_o <= errors;
    pending_o     <= expect_q.size();
    returns_o     <= returned;
  end

endmodule

//--- tb/mc_subsystem_tb.sv
`timescale 1ns/1ps

module mc_subsystem_tb;

  localparam int num_tests_c = 23;
  localparam int timeout_c   = num_tests_c * 40 + 50;

  localparam mc_link_pkg::mc_op_e op_ld = mc_link_pkg::mc_op_load;
  localparam mc_link_pkg::mc_op_e op_st = mc_link_pkg::mc_op_store;

  typedef struct packed {
    mc_link_pkg::mc_op_e op;
    logic [13:0]         addr;
    logic [1:0]          part_sel;
    logic [31:0]         data;
    logic                stall; // Random host stalls on returns.
  } stim_s;

  logic                      clk_i = 1'b0;
  logic                      reset_i = 1'b1;
  mc_link_pkg::mc_fwd_link_s req_i = '0;
  logic                      req_ready_o;
  mc_link_pkg::mc_ret_link_s ret_o;
  logic                      ret_ready_i = 1'b0;

  stim_s        stim_tbl [num_tests_c];
  logic [127:0] name_tbl [num_tests_c];
  logic [127:0] cur_name = '0;
  int           n_entries = 0;
  logic         stall_mode = 1'b0;
  logic         run_done = 1'b0;
  integer       seed = 32'hbdcb5d3a;
  int           cycles = 0;
  int           error_count;
  int           pending;
  int           returns;
  int           assert_fails;

  mc_subsystem_top dut0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .ret_o       (ret_o),
    .ret_ready_i (ret_ready_i)
  );

  mc_subsystem_checker checker0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .req_ready_i   (req_ready_o),
    .ret_i         (ret_o),
    .ret_ready_i   (ret_ready_i),
    .test_name_i   (cur_name),
    .end_i         (run_done),
    .error_count_o (error_count),
    .pending_o     (pending),
    .returns_o     (returns)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (stall_mode) begin
      ret_ready_i <= (($random(seed) & 3) != 0); // Low about one cycle in four.
    end else begin
      ret_ready_i <= 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_c) begin
      $display("Timeout after %0d cycles, %0d returns did not arrive", cycles, pending);
      $display("Test failed");
      $finish;
    end
  end

  task automatic add_entry(input logic [127:0] name, input mc_link_pkg::mc_op_e op,
                           input logic [13:0] addr, input logic [1:0] part_sel,
                           input logic [31:0] data, input logic stall);
    name_tbl[n_entries] = name;
    stim_tbl[n_entries] = {op, addr, part_sel, data, stall};
    n_entries++;
  endtask

  function automatic mc_link_pkg::mc_fwd_packet_s make_pkt(input stim_s s);
    mc_link_pkg::mc_fwd_packet_s pkt;
    pkt.op   = s.op;
    pkt.addr = s.addr;
    if (s.op == op_st) begin
      pkt.payload.data = s.data;
    end else begin
      pkt.payload.load_info.zero     = '0;
      pkt.payload.load_info.part_sel = s.part_sel;
    end
    return pkt;
  endfunction

  task automatic fill_table();
    add_entry("rst_ld_lo",    op_ld, 14'h005, 2'd0, 32'h0,         1'b0);
    add_entry("rst_ld_hi",    op_ld, 14'h085, 2'd2, 32'h0,         1'b0);
    add_entry("st_lo",        op_st, 14'h003, 2'd0, 32'ha1b2c3d4, 1'b0);
    add_entry("ld_lo_b0",     op_ld, 14'h003, 2'd0, 32'h0,         1'b0);
    add_entry("ld_lo_b3",     op_ld, 14'h003, 2'd3, 32'h0,         1'b0);
    add_entry("st_hi",        op_st, 14'h043, 2'd0, 32'h11223344, 1'b0);
    add_entry("ld_hi_b1",     op_ld, 14'h043, 2'd1, 32'h0,         1'b0);
    add_entry("ld_lo_sep",    op_ld, 14'h003, 2'd2, 32'h0,         1'b0);
    add_entry("st_hi_alias",  op_st, 14'h083, 2'd0, 32'h55667788, 1'b0);
    add_entry("ld_hi_alias",  op_ld, 14'h043, 2'd0, 32'h0,         1'b0);
    add_entry("st_edge_fc",   op_st, 14'h03f, 2'd0, 32'hcafef00d, 1'b0);
    add_entry("st_edge_100",  op_st, 14'h040, 2'd0, 32'hdeadbeef, 1'b0);
    add_entry("ld_edge_ff",   op_ld, 14'h03f, 2'd3, 32'h0,         1'b0);
    add_entry("ld_edge_100",  op_ld, 14'h040, 2'd0, 32'h0,         1'b0);
    add_entry("ld_alt_lo",    op_ld, 14'h03f, 2'd1, 32'h0,         1'b0);
    add_entry("ld_alt_hi",    op_ld, 14'h040, 2'd3, 32'h0,         1'b0);
    // Same words on the other side stay untouched by the edge stores.
    add_entry("ld_alias_1ff", op_ld, 14'h07f, 2'd3, 32'h0,         1'b0);
    add_entry("ld_alias_000", op_ld, 14'h000, 2'd0, 32'h0,         1'b0);
    add_entry("st_bp_lo",     op_st, 14'h010, 2'd0, 32'h0badcafe, 1'b1);
    add_entry("st_bp_hi",     op_st, 14'h050, 2'd0, 32'h12345678, 1'b1);
    add_entry("ld_bp_lo",     op_ld, 14'h010, 2'd1, 32'h0,         1'b1);
    add_entry("ld_bp_hi",     op_ld, 14'h050, 2'd2, 32'h0,         1'b1);
    add_entry("ld_bp_lo2",    op_ld, 14'h010, 2'd3, 32'h0,         1'b1);
  endtask

  initial begin
    fill_table();
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      stall_mode <= stim_tbl[i].stall;
      cur_name   <= name_tbl[i];
      req_i      <= {1'b1, make_pkt(stim_tbl[i])};
      @(posedge clk_i);
      while (!req_ready_o) @(posedge clk_i);
    end
    req_i      <= '0;
    stall_mode <= 1'b0;
    @(posedge clk_i);
    while (pending != 0) @(posedge clk_i);
    run_done <= 1'b1;
    repeat (2) @(posedge clk_i);
    assert_fails = dut0.switch_u.switch_checks.fail_count;
    $display("Summary: %0d returns checked, %0d checker errors, %0d assertion failures",
             returns, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
